//--- source/mem_delay_macros.svh
`ifndef MEM_DELAY_MACROS_SVH
`define MEM_DELAY_MACROS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define MEM_DELAY_ADDR_W 23                        // Host word address.
`define MEM_DELAY_DATA_W 32
`define MEM_DELAY_BE_W   (`MEM_DELAY_DATA_W / 8)   // One enable per byte.
`define MEM_DELAY_CSR_AW 3

// ----------------------------------------------------------------------
// Control registers
// ----------------------------------------------------------------------
`define MEM_DELAY_CSR_ENABLE  3'd0
`define MEM_DELAY_CSR_COUNT   3'd4
`define MEM_DELAY_COUNT_RESET 32'd1

// Word address bits decoded by the memory.
`define MEM_DELAY_SRAM_AW 8

`endif

//--- source/mem_delay_pkg.sv
`include "mem_delay_macros.svh"

package mem_delay_pkg;

  // ----------------------------------------------------------------------
  // Memory bus request
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`MEM_DELAY_ADDR_W-1:0] address;
    logic [`MEM_DELAY_BE_W-1:0]   byteenable;
    logic                         chipselect;
    logic                         clken;      // Carried along, unused by memory.
    logic                         read;
    logic                         write;
    logic [`MEM_DELAY_DATA_W-1:0] writedata;
  } mem_req_t;

  // ----------------------------------------------------------------------
  // Control register word
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`MEM_DELAY_DATA_W-2:0] reserved;
    logic                         enable;     // Bit 0.
  } csr_ctrl_t;

  // Same word seen as enable register or as delay count.
  typedef union packed {
    csr_ctrl_t                    ctrl;
    logic [`MEM_DELAY_DATA_W-1:0] count;
  } csr_word_u;

  typedef struct packed {
    logic                         write;
    logic [`MEM_DELAY_CSR_AW-1:0] address;
    csr_word_u                    data;
  } csr_cmd_t;

  // ----------------------------------------------------------------------
  // Delay configuration
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                         enable;
    logic [`MEM_DELAY_DATA_W-1:0] count_max;  // Extra wait cycles.
  } delay_cfg_t;

endpackage

//--- source/csr_regs.sv
`include "mem_delay_macros.svh"

module csr_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  mem_delay_pkg::csr_cmd_t   csr_cmd,
  output mem_delay_pkg::delay_cfg_t cfg
);

  logic enable_hit;
  logic count_hit;

  // ----------------------------------------------------------------------
  // Offset decode
  // ----------------------------------------------------------------------
  assign enable_hit = csr_cmd.write && (csr_cmd.address == `MEM_DELAY_CSR_ENABLE);
  assign count_hit  = csr_cmd.write && (csr_cmd.address == `MEM_DELAY_CSR_COUNT);

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg.enable    <= 1'b0;
      cfg.count_max <= `MEM_DELAY_COUNT_RESET;
    end else begin
      if (enable_hit) begin
        cfg.enable <= csr_cmd.data.ctrl.enable;     // Bit 0 of the control view.
      end
      if (count_hit) begin
        cfg.count_max <= csr_cmd.data.count;        // Whole word in the count view.
      end
    end
  end

endmodule

//--- source/delay_bridge.sv
`include "mem_delay_macros.svh"

module delay_bridge (
  input  logic                         clk,
  input  logic                         reset,
  input  mem_delay_pkg::delay_cfg_t    cfg,
  input  mem_delay_pkg::mem_req_t      host_req,
  output logic [`MEM_DELAY_DATA_W-1:0] host_readdata,
  output logic                         host_waitrequest,
  output mem_delay_pkg::mem_req_t      mem_req,
  input  logic [`MEM_DELAY_DATA_W-1:0] mem_readdata,
  input  logic                         mem_waitrequest
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COUNT,
    ST_EXECUTE,
    ST_DONE
  } state_t;

  state_t                       state;
  state_t                       state_next;
  logic [`MEM_DELAY_DATA_W-1:0] count;
  logic                         count_hit;
  logic                         delay_done;
  logic                         host_access;

  assign host_access = host_req.chipselect && (host_req.read || host_req.write);
  assign count_hit   = (count == cfg.count_max);
  assign delay_done  = !cfg.enable || count_hit;   // Delay off leaves after one cycle.

  // ----------------------------------------------------------------------
  // Delay counter
  // ----------------------------------------------------------------------
  // Runs only while waiting, back to zero on reaching the limit.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (state == ST_COUNT && !count_hit) begin
      count <= count + 1'b1;
    end else begin
      count <= '0;
    end
  end

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (host_access) begin
          state_next = ST_COUNT;
        end
      end
      ST_COUNT: begin
        if (delay_done) begin
          state_next = host_req.write ? ST_EXECUTE : ST_DONE;  // Reads skip execute.
        end
      end
      ST_EXECUTE: begin
        if (!mem_waitrequest) begin
          state_next = ST_DONE;                  // Memory stall cleared.
        end
      end
      ST_DONE: begin
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Memory side
  // ----------------------------------------------------------------------
  always_comb begin
    mem_req       = host_req;                    // Address, data, enables.
    mem_req.read  = 1'b0;                        // Reads are asynchronous in memory.
    mem_req.write = cfg.enable ? (state == ST_EXECUTE) : host_req.write;
  end

  assign host_readdata    = mem_readdata;
  assign host_waitrequest = (state != ST_DONE);

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  property p_wait_single;
    @(posedge clk) disable iff (reset)
      !host_waitrequest |=> host_waitrequest;
  endproperty

  // Host keeps chipselect up for the whole access.
  property p_write_cs;
    @(posedge clk) disable iff (reset)
      mem_req.write |-> mem_req.chipselect;
  endproperty

  a_wait_single: assert property (p_wait_single)
    else $error("host_waitrequest low for two cycles");

  a_write_cs: assert property (p_write_cs)
    else $error("memory write strobe without chipselect");

endmodule

//--- source/sram_bank.sv
`include "mem_delay_macros.svh"

module sram_bank (
  input  logic                         clk,
  input  logic                         reset,
  input  mem_delay_pkg::mem_req_t      mem_req,
  output logic [`MEM_DELAY_DATA_W-1:0] mem_readdata,
  output logic                         mem_waitrequest
);

  localparam int DEPTH = 1 << `MEM_DELAY_SRAM_AW;

  logic [`MEM_DELAY_DATA_W-1:0] mem [DEPTH];
  logic [`MEM_DELAY_SRAM_AW-1:0] index;
  logic                          write_q;
  logic                          stall;
  logic                          do_write;

  assign index    = mem_req.address[`MEM_DELAY_SRAM_AW-1:0];  // Upper bits ignored.
  assign stall    = mem_req.write && !write_q;                // First write cycle.
  assign do_write = mem_req.chipselect && mem_req.write && !stall;

  // ----------------------------------------------------------------------
  // Write stall
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      write_q <= 1'b0;
    end else begin
      write_q <= mem_req.write;
    end
  end

  assign mem_waitrequest = stall;

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int b = 0; b < `MEM_DELAY_BE_W; b++) begin
        if (mem_req.byteenable[b]) begin
          mem[index][8*b +: 8] <= mem_req.writedata[8*b +: 8];  // Byte merge.
        end
      end
    end
  end

  assign mem_readdata = mem[index];  // Asynchronous read.

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // A write always lands after its stall cycle, never inside it.
  property p_write_after_stall;
    @(posedge clk) disable iff (reset)
      do_write |-> $past(mem_req.write);
  endproperty

  a_write_after_stall: assert property (p_write_after_stall)
    else $error("memory write during the stall cycle");

endmodule

//--- source/mem_delay_top.sv
`include "mem_delay_macros.svh"

module mem_delay_top (
  input  logic                         clk,
  input  logic                         reset,
  input  mem_delay_pkg::csr_cmd_t      csr_cmd,
  input  mem_delay_pkg::mem_req_t      host_req,
  output logic [`MEM_DELAY_DATA_W-1:0] host_readdata,
  output logic                         host_waitrequest
);

  import mem_delay_pkg::*;

  delay_cfg_t                   cfg;             // Enable and count limit.
  mem_req_t                     mem_req;         // Bridge to memory.
  logic [`MEM_DELAY_DATA_W-1:0] mem_readdata;
  logic                         mem_waitrequest;

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------
  csr_regs u_csr_regs (
    .clk     (clk),
    .reset   (reset),
    .csr_cmd (csr_cmd),
    .cfg     (cfg)
  );

  // ----------------------------------------------------------------------
  // Delay bridge
  // ----------------------------------------------------------------------
  delay_bridge u_delay_bridge (
    .clk              (clk),
    .reset            (reset),
    .cfg              (cfg),
    .host_req         (host_req),
    .host_readdata    (host_readdata),
    .host_waitrequest (host_waitrequest),
    .mem_req          (mem_req),
    .mem_readdata     (mem_readdata),
    .mem_waitrequest  (mem_waitrequest)
  );

  // ----------------------------------------------------------------------
  // Memory
  // ----------------------------------------------------------------------
  sram_bank u_sram_bank (
    .clk             (clk),
    .reset           (reset),
    .mem_req         (mem_req),
    .mem_readdata    (mem_readdata),
    .mem_waitrequest (mem_waitrequest)
  );

endmodule

//--- test/clock_gen.sv
module clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;              // 100 ns period.
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 reset = 1'b0;                    // Released with the stimulus offset.
  end

endmodule

//--- test/mem_delay_tb.sv
`include "mem_delay_macros.svh"

module mem_delay_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_delay_pkg::*;

  localparam logic [31:0] SEED = 32'h01e4_59cf;
  localparam int CYCLE_LIMIT = 4000;
  localparam int ACCESS_LIMIT = 40;
  localparam int POOL_SIZE = 8;
  localparam int DEPTH = 1 << `MEM_DELAY_SRAM_AW;

  logic                         clk;
  logic                         reset;
  csr_cmd_t                     csr_cmd;
  mem_req_t                     host_req;
  logic [`MEM_DELAY_DATA_W-1:0] host_readdata;
  logic                         host_waitrequest;

  logic [`MEM_DELAY_DATA_W-1:0]  shadow [DEPTH];  // Expected memory contents.
  logic [`MEM_DELAY_SRAM_AW-1:0] pool [POOL_SIZE]; // Word indexes in use.
  logic                          exp_enable;
  logic [`MEM_DELAY_DATA_W-1:0]  exp_count;
  logic [`MEM_DELAY_DATA_W-1:0]  exp_data;
  logic                          rd_active;
  logic                          wr_active;
  int                            acc_cycle;        // Cycle number inside an access.
  int                            exp_cycle;
  int                            errors;
  int                            err_mark;
  int                            tests;
  int                            accesses;
  int                            cycles = 0;

  clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  mem_delay_top u_mem_delay_top (
    .clk              (clk),
    .reset            (reset),
    .csr_cmd          (csr_cmd),
    .host_req         (host_req),
    .host_readdata    (host_readdata),
    .host_waitrequest (host_waitrequest)
  );

  // ----------------------------------------------------------------------
  // Reporting and reference model
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic log_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < `MEM_DELAY_BE_W; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Random upper bits, which the memory ignores.
  function automatic logic [`MEM_DELAY_ADDR_W-1:0] pick_addr();
    logic [`MEM_DELAY_ADDR_W-1:0] addr;
    addr = `MEM_DELAY_ADDR_W'($urandom);
    addr[`MEM_DELAY_SRAM_AW-1:0] = pool[$urandom_range(POOL_SIZE-1)];
    return addr;
  endfunction

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  a_reset_wait: assert property (@(posedge clk) reset |-> host_waitrequest)
    else report_mismatch("host_waitrequest low during reset");

  a_idle_wait: assert property (@(posedge clk) $fell(reset) |-> host_waitrequest)
    else report_mismatch("host_waitrequest low in first idle cycle");

  a_read_latency: assert property (@(posedge clk) disable iff (reset)
      rd_active |-> (host_waitrequest == (acc_cycle != exp_cycle)))
    else report_mismatch($sformatf("read wait level wrong in cycle %0d, end due in cycle %0d",
                                   acc_cycle, exp_cycle));

  a_read_data: assert property (@(posedge clk) disable iff (reset)
      (rd_active && !host_waitrequest) |-> (host_readdata == exp_data))
    else report_mismatch($sformatf("read data %h, expected %h",
                                   $sampled(host_readdata), exp_data));

  a_single_end: assert property (@(posedge clk) disable iff (reset)
      !host_waitrequest |=> host_waitrequest)
    else report_mismatch("host_waitrequest low for two cycles");

  a_end_in_access: assert property (@(posedge clk) disable iff (reset)
      !host_waitrequest |-> (rd_active || wr_active))
    else report_mismatch("host_waitrequest low with no access pending");

  a_access_limit: assert property (@(posedge clk) disable iff (reset)
      (rd_active || wr_active) |-> (acc_cycle <= ACCESS_LIMIT))
    else log_failure("an access did not complete within the cycle limit");

  // ----------------------------------------------------------------------
  // Bus tasks
  // ----------------------------------------------------------------------
  task automatic write_csr(input logic [2:0] offset, input logic [31:0] value);
    csr_cmd.write      = 1'b1;
    csr_cmd.address    = offset;
    csr_cmd.data.count = value;
    @(posedge clk);
    #10;
    csr_cmd = '0;
    if (offset == `MEM_DELAY_CSR_ENABLE) begin
      exp_enable = value[0];
    end else if (offset == `MEM_DELAY_CSR_COUNT) begin
      exp_count = value;
    end
  endtask

  task automatic run_access(input logic                         is_write,
                            input logic [`MEM_DELAY_ADDR_W-1:0] addr,
                            input logic [3:0]                   be,
                            input logic [31:0]                  data);
    logic ended;
    int   idx;
    idx                 = addr[`MEM_DELAY_SRAM_AW-1:0];
    host_req.address    = addr;
    host_req.byteenable = be;
    host_req.chipselect = 1'b1;
    host_req.clken      = 1'($urandom);
    host_req.read       = !is_write;
    host_req.write      = is_write;
    host_req.writedata  = data;
    exp_cycle = exp_enable ? int'(exp_count) + 3 : 3;
    exp_data  = shadow[idx];
    acc_cycle = 1;
    rd_active = !is_write;
    wr_active = is_write;
    ended     = 1'b0;
    while (!ended) begin
      @(negedge clk);
      ended = !host_waitrequest;        // Mid-cycle, outputs settled.
      @(posedge clk);
      #10;
      if (!ended) begin
        acc_cycle++;
      end
    end
    rd_active = 1'b0;
    wr_active = 1'b0;
    host_req  = '0;
    if (is_write) begin
      shadow[idx] = merge_bytes(shadow[idx], data, be);
    end
    accesses++;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %-14s done at %0t ns, %0d errors", name, $time, errors - err_mark);
    err_mark = errors;
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic fill_memory();
    logic [`MEM_DELAY_ADDR_W-1:0] addr;
    for (int i = 0; i < POOL_SIZE; i++) begin
      addr = `MEM_DELAY_ADDR_W'($urandom);
      addr[`MEM_DELAY_SRAM_AW-1:0] = pool[i];
      run_access(1'b1, addr, 4'hf, $urandom);
    end
    finish_test("fill");
  endtask

  task automatic read_plain();
    for (int i = 0; i < 8; i++) begin
      run_access(1'b0, pick_addr(), 4'hf, $urandom);
    end
    finish_test("read_no_delay");
  endtask

  task automatic read_delayed();
    int delays [4];
    delays = '{0, 1, 5, 0};
    delays[3] = $urandom_range(12);
    write_csr(`MEM_DELAY_CSR_ENABLE, 32'd1);
    foreach (delays[k]) begin
      write_csr(`MEM_DELAY_CSR_COUNT, delays[k]);
      for (int i = 0; i < 4; i++) begin
        run_access(1'b0, pick_addr(), 4'hf, $urandom);
      end
    end
    finish_test("read_delay");
  endtask

  task automatic write_mixed();
    logic [`MEM_DELAY_ADDR_W-1:0] addr;
    logic [3:0]                   be;
    for (int mode = 0; mode < 2; mode++) begin
      write_csr(`MEM_DELAY_CSR_ENABLE, mode);
      write_csr(`MEM_DELAY_CSR_COUNT, $urandom_range(4));
      for (int i = 0; i < 6; i++) begin
        addr = pick_addr();
        be   = (i == 0) ? 4'hf : 4'($urandom_range(1, 15));
        run_access(1'b1, addr, be, $urandom);
        run_access(1'b0, addr, 4'hf, $urandom);
      end
    end
    finish_test("write_merge");
  endtask

  task automatic csr_offsets();
    logic [2:0] unused [6];
    unused = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
    write_csr(`MEM_DELAY_CSR_ENABLE, 32'd1);
    write_csr(`MEM_DELAY_CSR_COUNT, 32'd2);
    foreach (unused[k]) begin
      write_csr(unused[k], $urandom);
      run_access(1'b0, pick_addr(), 4'hf, $urandom);
    end
    write_csr(`MEM_DELAY_CSR_COUNT, 32'd7);   // Longer wait from the next read.
    run_access(1'b0, pick_addr(), 4'hf, $urandom);
    run_access(1'b0, pick_addr(), 4'hf, $urandom);
    write_csr(`MEM_DELAY_CSR_ENABLE, 32'd0);
    run_access(1'b0, pick_addr(), 4'hf, $urandom);
    finish_test("csr_offsets");
  endtask

  // ----------------------------------------------------------------------
  // Run control
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles, an access never completed", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    csr_cmd    = '0;
    host_req   = '0;
    rd_active  = 1'b0;
    wr_active  = 1'b0;
    acc_cycle  = 0;
    exp_cycle  = 0;
    exp_data   = '0;
    exp_enable = 1'b0;
    exp_count  = `MEM_DELAY_COUNT_RESET;
    errors     = 0;
    err_mark   = 0;
    tests      = 0;
    accesses   = 0;
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = `MEM_DELAY_SRAM_AW'($urandom);
    end
    wait (reset === 1'b0);
    @(posedge clk);
    #10;
    finish_test("reset");
    fill_memory();
    read_plain();
    read_delayed();
    write_mixed();
    csr_offsets();
    repeat (2) @(posedge clk);             // Let the last checks settle.
    $display("tests %0d, accesses %0d, errors %0d", tests, accesses, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- mem_delay.f
+incdir+source
source/mem_delay_pkg.sv
source/csr_regs.sv
source/delay_bridge.sv
source/sram_bank.sv
source/mem_delay_top.sv
test/clock_gen.sv
test/mem_delay_tb.sv
